//--- fetch_pkg.sv
// instruction fetch shared definitions
package fetch_pkg;

   // cache line geometry, also the size of the instruction window
   localparam int line_bytes_c = 16;
   localparam int line_bits_c  = line_bytes_c * 8;

   // linear address width
   localparam int addr_bits_c = 32;

   // instruction length from decode, 1 to 15 bytes
   localparam int len_bits_c = 4;

   // fetch sequencing states
   //   st_start  first cycle out of reset, loads the start address
   //   st_fill   requesting lines while the ring has room
   //   st_full   ring holds NUM_LINES unread lines
   //   st_flush  restart from a new eip and cs
   typedef enum logic [1:0] {
      st_start = 2'd0,
      st_fill  = 2'd1,
      st_full  = 2'd2,
      st_flush = 2'd3
   } fetch_state_e;

endpackage

//--- fetch_control.sv
// fetch sequencing FSM
`timescale 1ns/1ns

module fetch_control
   import fetch_pkg::*;
#(
   parameter int NUM_LINES = 4
) (
   input  logic clk,
   input  logic rst_n,
   input  logic flush,
   input  logic dep_stall,
   input  logic icache_ready,
   input  logic full,
   input  logic ir_valid,
   output logic fetch_en,
   output logic write_en,
   output logic consume,
   output logic restart,
   output logic fetch_stall
);

   fetch_state_e state;
   fetch_state_e state_nxt;

   // ring indexing wraps on a power-of-two line count
   if (NUM_LINES < 2 || (NUM_LINES & (NUM_LINES - 1)) != 0) begin : g_bad_lines
      $error("NUM_LINES must be a power of two of at least 2");
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_start;
      end else begin
         state <= state_nxt;
      end
   end

   // flush wins from any state
   always_comb begin
      state_nxt = state;
      if (flush) begin
         state_nxt = st_flush;
      end else begin
         case (state)
            st_start: begin
               state_nxt = st_fill;
            end
            st_flush: begin
               state_nxt = st_fill;
            end
            st_fill: begin
               if (full) begin
                  state_nxt = st_full;
               end
            end
            st_full: begin
               // full already drops in the cycle a line is freed
               if (!full) begin
                  state_nxt = st_fill;
               end
            end
            default: begin
               state_nxt = st_start;
            end
         endcase
      end
   end

   // start and flush both reload the address and empty the ring
   assign restart = (state == st_start) || (state == st_flush);

   // request held as a level until the cache answers
   assign fetch_en = (state == st_fill) && !full;
   assign write_en = fetch_en && icache_ready;

   // advance past the current instruction
   assign consume = ir_valid && !dep_stall && !flush &&
                    ((state == st_fill) || (state == st_full));

   assign fetch_stall = restart || !ir_valid;

   // an open request stays up until the cache answers or a flush comes
   a_request_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      (fetch_en && !icache_ready && !flush) |=> fetch_en
   );

   // a full ring always holds a whole window
   a_full_has_window: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_full) |-> ir_valid
   );

endmodule

//--- fetch_address.sv
// linear fetch address generation
`timescale 1ns/1ns

module fetch_address
   import fetch_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [addr_bits_c-1:0] eip,
   input  logic [15:0]            cs,
   input  logic                   restart,
   input  logic                   write_en,
   output logic [addr_bits_c-1:0] fetch_addr
);

   logic [addr_bits_c-1:0] start_addr;
   logic [addr_bits_c-1:0] next_line_addr;

   // segment base is cs shifted up 16 bits
   assign start_addr = eip + {cs, 16'h0000};

   // each accepted line moves on by a full line, no alignment
   assign next_line_addr = fetch_addr + addr_bits_c'(line_bytes_c);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch_addr <= '0;
      end else if (restart) begin
         fetch_addr <= start_addr;
      end else if (write_en) begin
         fetch_addr <= next_line_addr;
      end
   end

endmodule

//--- line_buffer.sv
// ring of fetched cache lines
`timescale 1ns/1ns

module line_buffer
   import fetch_pkg::*;
#(
   parameter int NUM_LINES = 4
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  write_en,
   input  logic                                  restart,
   input  logic                                  line_freed,
   input  logic [line_bits_c-1:0]                icache_data,
   output logic [NUM_LINES-1:0][line_bits_c-1:0] lines,
   output logic [$clog2(NUM_LINES+1)-1:0]        lines_held,
   output logic                                  full
);

   localparam int WPTR_BITS = $clog2(NUM_LINES);
   localparam int CNT_BITS  = $clog2(NUM_LINES + 1);

   logic [WPTR_BITS-1:0] wr_ptr;

   // line storage
   always_ff @(posedge clk) begin
      if (write_en) begin
         lines[wr_ptr] <= icache_data;
      end
   end

   // write pointer wraps with the ring
   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         wr_ptr <= '0;
      end else if (write_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // held lines, up on a write and down when the reader leaves a line
   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         lines_held <= '0;
      end else begin
         case ({write_en, line_freed})
            2'b10: lines_held <= lines_held + 1'b1;
            2'b01: lines_held <= lines_held - 1'b1;
            default: lines_held <= lines_held;
         endcase
      end
   end

   // a line freed this cycle makes room for the next request at once
   assign full = (lines_held == CNT_BITS'(NUM_LINES)) && !line_freed;

   a_held_in_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      lines_held <= CNT_BITS'(NUM_LINES)
   );

endmodule

//--- read_tracker.sv
// byte read pointer and instruction pointer tracking
`timescale 1ns/1ns

module read_tracker
   import fetch_pkg::*;
#(
   parameter int NUM_LINES = 4,
   parameter int PTR_BITS  = 6
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           consume,
   input  logic                           restart,
   input  logic [len_bits_c-1:0]          instr_len,
   input  logic [addr_bits_c-1:0]         eip,
   input  logic [$clog2(NUM_LINES+1)-1:0] lines_held,
   output logic [PTR_BITS-1:0]            read_ptr,
   output logic [addr_bits_c-1:0]         eip_out,
   output logic                           ir_valid,
   output logic                           line_freed
);

   localparam int OFF_BITS   = $clog2(line_bytes_c);
   localparam int CNT_BITS   = $clog2(NUM_LINES + 1);
   localparam int AVAIL_BITS = CNT_BITS + OFF_BITS;

   logic [PTR_BITS-1:0]   read_ptr_nxt;
   logic [OFF_BITS-1:0]   byte_off;
   logic [AVAIL_BITS-1:0] bytes_held;
   logic [AVAIL_BITS-1:0] bytes_needed;

   assign read_ptr_nxt = read_ptr + {{(PTR_BITS - len_bits_c){1'b0}}, instr_len};
   assign byte_off     = read_ptr[OFF_BITS-1:0];

   // bytes held from the start of the current line
   assign bytes_held = {lines_held, {OFF_BITS{1'b0}}};

   // a full window past the current offset has to be in the ring,
   // compared this way so an empty ring never underflows
   assign bytes_needed = {{CNT_BITS{1'b0}}, byte_off} + AVAIL_BITS'(line_bytes_c);
   assign ir_valid     = (bytes_held >= bytes_needed);

   // lengths stay below a line, so at most one boundary is crossed
   assign line_freed = consume &&
                       (read_ptr_nxt[PTR_BITS-1:OFF_BITS] != read_ptr[PTR_BITS-1:OFF_BITS]);

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         read_ptr <= '0;
      end else if (consume) begin
         read_ptr <= read_ptr_nxt;
      end
   end

   // pointer of the instruction at the head of the window
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         eip_out <= '0;
      end else if (restart) begin
         eip_out <= eip;
      end else if (consume) begin
         eip_out <= eip_out + {{(addr_bits_c - len_bits_c){1'b0}}, instr_len};
      end
   end

endmodule

//--- byte_aligner.sv
// instruction window alignment across two lines
`timescale 1ns/1ns

module byte_aligner
   import fetch_pkg::*;
#(
   parameter int NUM_LINES = 4,
   parameter int PTR_BITS  = 6
) (
   input  logic [NUM_LINES-1:0][line_bits_c-1:0] lines,
   input  logic [PTR_BITS-1:0]                   read_ptr,
   output logic [line_bits_c-1:0]                ir_out
);

   localparam int OFF_BITS  = $clog2(line_bytes_c);
   localparam int IDX_BITS  = PTR_BITS - OFF_BITS;
   localparam int JOIN_BITS = 2 * line_bits_c;
   // first level shifts up to 3 bytes, second level steps of 4 bytes
   localparam int FINE_BITS = line_bits_c + (line_bytes_c - 4) * 8;

   logic [IDX_BITS-1:0]  cur_idx;
   logic [IDX_BITS-1:0]  nxt_idx;
   logic [OFF_BITS-1:0]  byte_off;
   logic [JOIN_BITS-1:0] joined;
   logic [FINE_BITS-1:0] fine;

   assign cur_idx  = read_ptr[PTR_BITS-1:OFF_BITS];
   assign nxt_idx  = cur_idx + 1'b1;
   assign byte_off = read_ptr[OFF_BITS-1:0];

   // byte 0 sits in the top bits, so the current line goes high
   assign joined = {lines[cur_idx], lines[nxt_idx]};

   // level one, 0 to 3 bytes
   assign fine = joined[(JOIN_BITS - 1) - 8 * byte_off[1:0] -: FINE_BITS];

   // level two, 0, 4, 8 or 12 bytes
   assign ir_out = fine[(FINE_BITS - 1) - 32 * byte_off[OFF_BITS-1:2] -: line_bits_c];

endmodule

//--- fetch_top.sv
// instruction fetch front end
`timescale 1ns/1ns

module fetch_top
   import fetch_pkg::*;
#(
   parameter int NUM_LINES = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [addr_bits_c-1:0] eip,
   input  logic [15:0]            cs,
   input  logic [line_bits_c-1:0] icache_data,
   input  logic                   icache_ready,
   input  logic [len_bits_c-1:0]  instr_len,
   input  logic                   dep_stall,
   input  logic                   flush,
   output logic [addr_bits_c-1:0] fetch_addr,
   output logic                   fetch_en,
   output logic [line_bits_c-1:0] ir_out,
   output logic                   ir_valid,
   output logic [addr_bits_c-1:0] eip_out,
   output logic                   fetch_stall
);

   localparam int PTR_BITS = $clog2(NUM_LINES * line_bytes_c);
   localparam int CNT_BITS = $clog2(NUM_LINES + 1);

   logic                                  write_en;
   logic                                  restart;
   logic                                  consume;
   logic                                  full;
   logic                                  line_freed;
   logic [CNT_BITS-1:0]                   lines_held;
   logic [PTR_BITS-1:0]                   read_ptr;
   logic [NUM_LINES-1:0][line_bits_c-1:0] lines;

   fetch_control #(
      .NUM_LINES (NUM_LINES)
   ) control_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .dep_stall    (dep_stall),
      .icache_ready (icache_ready),
      .full         (full),
      .ir_valid     (ir_valid),
      .fetch_en     (fetch_en),
      .write_en     (write_en),
      .consume      (consume),
      .restart      (restart),
      .fetch_stall  (fetch_stall)
   );

   fetch_address address_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .eip        (eip),
      .cs         (cs),
      .restart    (restart),
      .write_en   (write_en),
      .fetch_addr (fetch_addr)
   );

   line_buffer #(
      .NUM_LINES (NUM_LINES)
   ) buffer_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .write_en    (write_en),
      .restart     (restart),
      .line_freed  (line_freed),
      .icache_data (icache_data),
      .lines       (lines),
      .lines_held  (lines_held),
      .full        (full)
   );

   read_tracker #(
      .NUM_LINES (NUM_LINES),
      .PTR_BITS  (PTR_BITS)
   ) tracker_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .consume    (consume),
      .restart    (restart),
      .instr_len  (instr_len),
      .eip        (eip),
      .lines_held (lines_held),
      .read_ptr   (read_ptr),
      .eip_out    (eip_out),
      .ir_valid   (ir_valid),
      .line_freed (line_freed)
   );

   byte_aligner #(
      .NUM_LINES (NUM_LINES),
      .PTR_BITS  (PTR_BITS)
   ) aligner_i (
      .lines    (lines),
      .read_ptr (read_ptr),
      .ir_out   (ir_out)
   );

endmodule

//--- tb_icache_model.sv
// instruction cache model
`timescale 1ns/1ns

module tb_icache_model
   import fetch_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   fetch_en,
   input  logic [addr_bits_c-1:0] fetch_addr,
   input  logic [2:0]             latency,
   output logic                   icache_ready,
   output logic [line_bits_c-1:0] icache_data
);

   logic waiting;
   int   remain;

   // byte k of the line at address a holds the low bits of a + k
   function automatic logic [line_bits_c-1:0] line_pattern(input logic [addr_bits_c-1:0] addr);
      logic [line_bits_c-1:0] line;
      line = '0;
      for (int k = 0; k < line_bytes_c; k++) begin
         line[line_bits_c - 1 - 8 * k -: 8] = 8'(addr + k);
      end
      return line;
   endfunction

   initial begin
      icache_ready = 1'b0;
      icache_data  = '0;
      waiting      = 1'b0;
      remain       = 0;
   end

   // acts 2 ns after the edge, once fetch_en has settled
   always @(posedge clk) begin
      #2;
      icache_ready = 1'b0;
      if (!rst_n || !fetch_en) begin
         // request dropped, nothing comes back for it
         waiting = 1'b0;
      end else begin
         if (!waiting) begin
            waiting = 1'b1;
            remain  = latency;
         end
         if (remain <= 1) begin
            icache_ready = 1'b1;
            icache_data  = line_pattern(fetch_addr);
            waiting      = 1'b0;
         end else begin
            remain = remain - 1;
         end
      end
   end

endmodule

//--- tb_fetch.sv
// fetch front end testbench
`timescale 1ns/1ns

module tb_fetch
   import fetch_pkg::*;
();

   localparam int ring_lines       = 4;
   localparam int num_phases       = 4;
   localparam int cycles_per_phase = 400;
   localparam int timeout_cycles   = num_phases * cycles_per_phase;

   logic                   clk;
   logic                   rst_n;
   logic [addr_bits_c-1:0] eip;
   logic [15:0]            cs;
   logic [line_bits_c-1:0] icache_data;
   logic                   icache_ready;
   logic [len_bits_c-1:0]  instr_len;
   logic                   dep_stall;
   logic                   flush;
   logic [addr_bits_c-1:0] fetch_addr;
   logic                   fetch_en;
   logic [line_bits_c-1:0] ir_out;
   logic                   ir_valid;
   logic [addr_bits_c-1:0] eip_out;
   logic                   fetch_stall;
   logic [2:0]             cache_latency;

   logic [15:0]            lfsr_state;
   int                     cycle_count = 0;
   int                     consume_total = 0;

   // reference state, counted since the last restart
   logic [addr_bits_c-1:0] ref_start = '0;
   logic [addr_bits_c-1:0] ref_eip = '0;
   int                     accepted = 0;
   int                     consumed = 0;
   logic                   restart_cycle = 1'b1;
   logic                   eip_known = 1'b0;
   logic                   prev_hold = 1'b0;
   logic [line_bits_c-1:0] prev_ir_out;
   logic [addr_bits_c-1:0] prev_eip_out;

   fetch_top #(
      .NUM_LINES (ring_lines)
   ) dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .eip          (eip),
      .cs           (cs),
      .icache_data  (icache_data),
      .icache_ready (icache_ready),
      .instr_len    (instr_len),
      .dep_stall    (dep_stall),
      .flush        (flush),
      .fetch_addr   (fetch_addr),
      .fetch_en     (fetch_en),
      .ir_out       (ir_out),
      .ir_valid     (ir_valid),
      .eip_out      (eip_out),
      .fetch_stall  (fetch_stall)
   );

   tb_icache_model cache_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .fetch_en     (fetch_en),
      .fetch_addr   (fetch_addr),
      .latency      (cache_latency),
      .icache_ready (icache_ready),
      .icache_data  (icache_data)
   );

   always #4 clk = ~clk;

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // window byte k is the low bits of its linear address
   function automatic logic [line_bits_c-1:0] expected_window(input logic [31:0] start_addr,
                                                              input int consumed_bytes);
      logic [line_bits_c-1:0] w;
      logic [31:0]            a;
      a = start_addr + consumed_bytes;
      for (int k = 0; k < line_bytes_c; k++) begin
         w[line_bits_c - 1 - 8 * k -: 8] = 8'(a + k);
      end
      return w;
   endfunction

   task automatic check_value(input logic [line_bits_c-1:0] actual,
                              input logic [line_bits_c-1:0] expected, input string what);
      if (actual !== expected) begin
         $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles) begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("TEST RESULT: FAIL");
         $fatal(1, "simulation timed out");
      end
   end

   // mid-cycle compare, all inputs and outputs settled
   always @(negedge clk) begin : compare
      int   avail;
      int   held;
      logic valid_exp;
      logic consume_exp;
      logic crossing;
      logic accept;
      if (!rst_n) begin
         if (cycle_count > 0) begin
            check_value(fetch_en, 1'b0, "fetch_en in reset");
            check_value(ir_valid, 1'b0, "ir_valid in reset");
            check_value(fetch_stall, 1'b1, "fetch_stall in reset");
         end
         restart_cycle = 1'b1;
         eip_known     = 1'b0;
         prev_hold     = 1'b0;
         accepted      = 0;
         consumed      = 0;
      end else begin
         avail     = accepted * line_bytes_c - consumed;
         held      = accepted - consumed / line_bytes_c;
         valid_exp = (avail >= line_bytes_c);
         check_value(ir_valid, valid_exp, "ir_valid");
         // pipeline held while restarting or short of a window
         check_value(fetch_stall, restart_cycle || !valid_exp, "fetch_stall");
         check_value(held <= ring_lines, 1'b1, "lines held in ring");
         if (valid_exp) begin
            check_value(ir_out, expected_window(ref_start, consumed), "ir_out window");
         end
         if (eip_known) begin
            check_value(eip_out, ref_eip, "eip_out");
         end
         // stalled edge leaves the window alone
         if (prev_hold) begin
            check_value(ir_out, prev_ir_out, "ir_out across stall");
            check_value(eip_out, prev_eip_out, "eip_out across stall");
         end
         consume_exp = valid_exp && !dep_stall && !flush && !restart_cycle;
         crossing    = consume_exp && ((consumed % line_bytes_c) + instr_len >= line_bytes_c);
         if (restart_cycle) begin
            check_value(fetch_en, 1'b0, "fetch_en during restart");
         end
         if (held == ring_lines && !crossing) begin
            check_value(fetch_en, 1'b0, "fetch_en with a full ring");
         end
         accept = fetch_en && icache_ready;
         if (accept) begin
            check_value(fetch_addr, ref_start + 32'(line_bytes_c * accepted), "fetch_addr");
         end
         prev_hold    = dep_stall && !restart_cycle && valid_exp;
         prev_ir_out  = ir_out;
         prev_eip_out = eip_out;
         if (restart_cycle) begin
            ref_start = eip + {cs, 16'h0000};
            ref_eip   = eip;
            accepted  = 0;
            consumed  = 0;
            eip_known = 1'b1;
         end else begin
            if (accept) begin
               accepted = accepted + 1;
            end
            if (consume_exp) begin
               consumed      = consumed + instr_len;
               ref_eip       = ref_eip + instr_len;
               consume_total = consume_total + 1;
            end
         end
         restart_cycle = flush;
      end
   end

   task automatic drive_cycle(input logic stall, input logic flush_in,
                              input logic [31:0] new_eip, input logic [15:0] new_cs);
      logic [3:0] len;
      @(posedge clk);
      #1;
      len = 4'(random_bits(4));
      if (len == 4'd0) begin
         len = 4'd1;
      end
      instr_len     = len;
      cache_latency = 3'(random_bits(2)) + 3'd1;
      dep_stall     = stall;
      flush         = flush_in;
      if (flush_in) begin
         eip = new_eip;
         cs  = new_cs;
      end
   endtask

   // runs until count more instructions have been consumed
   task automatic run_instructions(input int count, input int stall_weight,
                                   input logic with_flush);
      int   start_total;
      logic stall;
      logic flush_now;
      start_total = consume_total;
      while (consume_total - start_total < count) begin
         stall     = (random_bits(4) < stall_weight);
         flush_now = with_flush && (random_bits(5) == 0);
         drive_cycle(stall, flush_now, random_bits(32), 16'(random_bits(16)));
      end
   endtask

   task automatic hold_stall(input int cycles);
      repeat (cycles) begin
         drive_cycle(1'b1, 1'b0, '0, '0);
      end
      @(negedge clk);
      check_value(fetch_en, 1'b0, "fetch_en after long stall");
   endtask

   task automatic flush_to(input logic [31:0] new_eip, input logic [15:0] new_cs,
                           input logic [31:0] first_addr);
      logic seen;
      drive_cycle(1'b0, 1'b1, new_eip, new_cs);
      seen = 1'b0;
      while (!seen) begin
         drive_cycle(1'b0, 1'b0, '0, '0);
         @(negedge clk);
         if (fetch_en && icache_ready) begin
            check_value(fetch_addr, first_addr, "first fetch_addr after flush");
            seen = 1'b1;
         end
      end
   endtask

   initial begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      eip           = 32'h0000_0103;
      cs            = 16'h0002;
      instr_len     = 4'd1;
      dep_stall     = 1'b0;
      flush         = 1'b0;
      cache_latency = 3'd1;
      lfsr_state    = 16'd33736;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // initial fill and steady run with light stalls
      run_instructions(40, 3, 1'b0);
      // ring fills up behind a long stall
      hold_stall(40);
      run_instructions(40, 0, 1'b0);
      // flush to a new code segment
      flush_to(32'h0000_8ff7, 16'h0003, 32'h0003_8ff7);
      run_instructions(40, 4, 1'b0);
      // random flushes mixed in
      run_instructions(60, 3, 1'b1);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- build.f
fetch_pkg.sv
fetch_control.sv
fetch_address.sv
line_buffer.sv
read_tracker.sv
byte_aligner.sv
fetch_top.sv
tb_icache_model.sv
tb_fetch.sv
